// ==== compile.f ====
+incdir+include
verilog/mem_pkg.sv
verilog/mem_access_ctrl.sv
verilog/data_ram.sv
verilog/mem.sv
verilog/mem_subsys_top.sv
dv/mem_subsys_sva.sv
dv/tb_mem_subsys.sv

// ==== dv/mem_subsys_sva.sv ====
`timescale 1ns/10ps

module mem_subsys_sva import mem_pkg::*; (
    input logic       clk,
    input logic       reset_i,
    input logic       ex_valid_i,
    input logic       wb_valid_o,
    input mem_wb_t    wb_o,
    input dmem_req_t  dmem_req,
    input mem_stage_t stage
);

    // Fixed two-cycle latency, both directions
    valid_latency_a : assert property (
        @(posedge clk) disable iff (reset_i) ex_valid_i |-> ##2 wb_valid_o
    ) else $error("wb_valid_o missing two cycles after ex_valid_i");

    no_spurious_valid_a : assert property (
        @(posedge clk) disable iff (reset_i) wb_valid_o |-> $past(ex_valid_i, 2)
    ) else $error("wb_valid_o without a strobe two cycles earlier");

    // A write must never belong to a store flagged misaligned
    no_misaligned_write_a : assert property (
        @(posedge clk) disable iff (reset_i)
        dmem_req.we |=> !stage.exception[EXC_STORE_MISALIGN]
    ) else $error("RAM written by a misaligned store");

    reset_quiet_a : assert property (
        @(posedge clk) reset_i |=> (!wb_valid_o && !wb_o.regs_wen)
    ) else $error("writeback active during reset");

endmodule

bind mem_subsys_top mem_subsys_sva i_mem_subsys_sva (
    .clk        (clk),
    .reset_i    (reset_i),
    .ex_valid_i (ex_valid_i),
    .wb_valid_o (wb_valid_o),
    .wb_o       (wb_o),
    .dmem_req   (dmem_req),
    .stage      (stage)
);

// ==== dv/tb_mem_subsys.sv ====
`timescale 1ns/10ps

module tb_mem_subsys import mem_pkg::*;;

    typedef struct packed {
        mem_wb_t         wb;
        logic [XLEN-1:0] exc;
    } expect_t;

    logic            clk;
    logic            reset_i;
    logic            ex_valid_i;
    ex_mem_t         ex_i;
    logic            wb_valid_o;
    mem_wb_t         wb_o;
    logic [XLEN-1:0] exception_o;

    logic [7:0] shadow [DMEM_WORDS*4];
    expect_t    exp_q [$];
    string      name_q [$];
    integer     seed = 32'ha948_e27f;
    int         value_errs = 0;
    int         other_errs = 0;

    mem_subsys_top i_mem_subsys_top (
        .clk         (clk),
        .reset_i     (reset_i),
        .ex_valid_i  (ex_valid_i),
        .ex_i        (ex_i),
        .wb_valid_o  (wb_valid_o),
        .wb_o        (wb_o),
        .exception_o (exception_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ******************************
    // Reference model
    // ******************************

    function automatic expect_t predict(ex_mem_t ex);
        expect_t         e;
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [1:0]      lo;
        int              wbase;
        int              span;
        logic [31:0]     word;
        logic [15:0]     hv;
        logic [7:0]      bv;
        logic            mis;
        logic [XLEN-1:0] val;
        opc   = ex.inst[6:0];
        f3    = ex.inst[14:12];
        lo    = ex.mem_addr[1:0];
        wbase = ex.mem_addr[9:2] * 4;
        span  = (f3 == F3_W) ? 4 : (f3 == F3_H) ? 2 : 1;
        word  = {shadow[wbase+3], shadow[wbase+2], shadow[wbase+1], shadow[wbase]};
        bv    = shadow[wbase + lo];
        hv    = lo[1] ? word[31:16] : word[15:0];
        mis   = ((f3 == F3_H || f3 == F3_HU) && lo[0]) || (f3 == F3_W && lo != 2'b00);
        case (f3)
            F3_B:    val = {{24{bv[7]}}, bv};
            F3_H:    val = {{16{hv[15]}}, hv};
            F3_W:    val = word;
            F3_BU:   val = {24'b0, bv};
            F3_HU:   val = {16'b0, hv};
            default: val = '0;
        endcase
        if (opc == OPC_STORE) begin
            val = '0;
            if (!mis) begin
                for (int i = 0; i < 4; i++) begin
                    if (f3 == F3_W || (f3 == F3_H && i[1] == lo[1]) || (f3 == F3_B && i == lo))
                        shadow[wbase + i] = ex.store_data[8*(i%span) +: 8];
                end
            end
        end else if (opc != OPC_LOAD) begin
            val = (opc == OPC_OP_IMM || opc == OPC_OP || opc == OPC_JAL || opc == OPC_JALR ||
                   opc == OPC_LUI || opc == OPC_AUIPC) ? ex.rd_data : '0;
        end
        e.wb.inst        = ex.inst;
        e.wb.inst_addr   = ex.inst_addr;
        e.wb.regs_wen    = ex.regs_wen & ~(opc == OPC_LOAD && mis);
        e.wb.rd_addr     = ex.rd_addr;
        e.wb.rd_data     = val;
        e.wb.csr_wen     = ex.csr_wen;
        e.wb.csr_wr_addr = ex.csr_wr_addr;
        e.wb.csr_wr_data = ex.csr_wr_data;
        e.exc = ex.exception;
        e.exc[EXC_LOAD_MISALIGN]  = e.exc[EXC_LOAD_MISALIGN] | (opc == OPC_LOAD && mis);
        e.exc[EXC_STORE_MISALIGN] = e.exc[EXC_STORE_MISALIGN] | (opc == OPC_STORE && mis);
        return e;
    endfunction

    function automatic ex_mem_t make_ex(logic [6:0] opc, logic [2:0] f3,
                                        logic [31:0] addr, logic [31:0] data);
        ex_mem_t ex;
        ex.inst        = $random(seed);
        ex.inst[6:0]   = opc;
        ex.inst[14:12] = f3;
        ex.inst_addr   = $random(seed) & 32'hffff_fffc;
        ex.regs_wen    = (opc != OPC_STORE);
        ex.rd_addr     = $random(seed);
        ex.rd_data     = $random(seed);
        ex.mem_addr    = addr;
        ex.store_data  = data;
        ex.csr_wen     = $random(seed);
        ex.csr_wr_addr = $random(seed);
        ex.csr_wr_data = $random(seed);
        // Keep execute-side bits clear of the misalignment positions
        ex.exception   = $random(seed) & 32'h0f0f_0f0f;
        return ex;
    endfunction

    // ******************************
    // Stimulus and checks
    // ******************************

    task automatic send(string name, ex_mem_t ex);
        @(negedge clk);
        ex_valid_i = 1'b1;
        ex_i       = ex;
        exp_q.push_back(predict(ex));
        name_q.push_back(name);
    endtask

    task automatic drain();
        int n;
        @(negedge clk);
        ex_valid_i = 1'b0;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out: %0d results never appeared on writeback", exp_q.size());
            other_errs++;
            exp_q.delete();
            name_q.delete();
        end
    endtask

    task automatic check_wb(string name, mem_wb_t exp, mem_wb_t act);
        if (act !== exp) begin
            $display("error %s: wb expected %h actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_exc(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("error %s: exception expected %h actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    always @(negedge clk) begin : compare_proc
        expect_t e;
        string   name;
        if (!reset_i && wb_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Writeback produced a result that no instruction asked for");
                other_errs++;
            end else begin
                e    = exp_q.pop_front();
                name = name_q.pop_front();
                check_wb(name, e.wb, wb_o);
                check_exc(name, e.exc, exception_o);
            end
        end
    end

    initial begin
        logic [6:0] opc;
        logic [2:0] f3;
        reset_i    = 1'b1;
        ex_valid_i = 1'b0;
        ex_i       = '0;
        repeat (4) @(negedge clk);
        reset_i = 1'b0;

        // Quiet outputs from the last reset edge until the first strobe
        repeat (5) begin
            if (wb_valid_o !== 1'b0 || exception_o !== '0 ||
                wb_o.regs_wen !== 1'b0 || wb_o.csr_wen !== 1'b0) begin
                $display("Writeback not idle after reset before the first instruction");
                other_errs++;
            end
            @(negedge clk);
        end

        // Fill the 16-word test region
        for (int w = 0; w < 16; w++)
            send("fill", make_ex(OPC_STORE, F3_W, w * 4, 32'h9e37_79b9 * (w + 1) ^ (w << 20)));
        drain();

        send("sw_lw", make_ex(OPC_STORE, F3_W, 12, 32'hdead_beef));
        send("sw_lw", make_ex(OPC_LOAD, F3_W, 12, 0));
        send("op", make_ex(OPC_OP, 3'b000, 0, 0));
        send("store_csr", make_ex(OPC_STORE, F3_W, 8, 32'h1234_5678));
        drain();

        // Byte and halfword lanes, top bit set and clear
        for (int l = 0; l < 4; l++)
            send("sb", make_ex(OPC_STORE, F3_B, 16 + l, 32'h80 | (l * 32'h11)));
        send("sh", make_ex(OPC_STORE, F3_H, 20, 32'h0000_7abc));
        send("sh", make_ex(OPC_STORE, F3_H, 22, 32'h0000_8001));
        send("sb", make_ex(OPC_STORE, F3_B, 25, 32'h0000_005c));
        for (int l = 0; l < 4; l++) begin
            send("lb", make_ex(OPC_LOAD, F3_B, 16 + l, 0));
            send("lbu", make_ex(OPC_LOAD, F3_BU, 16 + l, 0));
            send("lb_pos", make_ex(OPC_LOAD, F3_B, 24 + l, 0));
        end
        for (int l = 0; l < 4; l += 2) begin
            send("lh", make_ex(OPC_LOAD, F3_H, 20 + l, 0));
            send("lhu", make_ex(OPC_LOAD, F3_HU, 20 + l, 0));
        end
        send("lw", make_ex(OPC_LOAD, F3_W, 16, 0));
        send("lw", make_ex(OPC_LOAD, F3_W, 20, 0));
        drain();

        send("mis_lh", make_ex(OPC_LOAD, F3_H, 29, 0));
        send("mis_lw", make_ex(OPC_LOAD, F3_W, 30, 0));
        send("mis_sh", make_ex(OPC_STORE, F3_H, 33, 32'hffff_ffff));
        send("mis_sw", make_ex(OPC_STORE, F3_W, 38, 32'hffff_ffff));
        send("mis_after", make_ex(OPC_LOAD, F3_W, 32, 0));
        send("mis_after", make_ex(OPC_LOAD, F3_W, 36, 0));
        drain();

        // Back-to-back random mix within the filled region
        for (int i = 0; i < 240; i++) begin
            case ($unsigned($random(seed)) % 3)
                0: begin
                    opc = OPC_LOAD;
                    case ($unsigned($random(seed)) % 5)
                        0: f3 = F3_B;
                        1: f3 = F3_H;
                        2: f3 = F3_W;
                        3: f3 = F3_BU;
                        default: f3 = F3_HU;
                    endcase
                end
                1: begin
                    opc = OPC_STORE;
                    f3  = $unsigned($random(seed)) % 3;
                end
                default: begin
                    case ($unsigned($random(seed)) % 6)
                        0: opc = OPC_OP_IMM;
                        1: opc = OPC_OP;
                        2: opc = OPC_JAL;
                        3: opc = OPC_JALR;
                        4: opc = OPC_LUI;
                        default: opc = OPC_AUIPC;
                    endcase
                    f3 = $random(seed);
                end
            endcase
            send("random", make_ex(opc, f3, $random(seed) & 32'h3f, $random(seed)));
        end
        drain();

        $display("Summary: %0d value errors, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== include/rv_opcodes.svh ====
`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

// ******************************
// RV32I major opcodes, inst[6:0]
// ******************************

`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_OP     7'b0110011
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111

// ******************************
// Load/store widths, inst[14:12]
// ******************************

`define RV_F3_B  3'b000
`define RV_F3_H  3'b001
`define RV_F3_W  3'b010
// Unsigned variants, loads only
`define RV_F3_BU 3'b100
`define RV_F3_HU 3'b101

`endif

// ==== verilog/data_ram.sv ====
`timescale 1ns/10ps

module data_ram import mem_pkg::*; (
    input  logic      clk,
    input  dmem_req_t req_i,
    output mem_word_u rdata_o
);

    mem_word_u ram [DMEM_WORDS];

    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (req_i.en && req_i.we) begin
            for (int i = 0; i < 4; i++) begin
                if (req_i.be[i]) begin
                    ram[req_i.addr].b[i] <= req_i.wdata.b[i];
                end
            end
        end
    end

    // Registered read, held over write cycles
    always_ff @(posedge clk) begin
        if (req_i.en && !req_i.we) begin
            rdata_o <= ram[req_i.addr];
        end
    end

endmodule

// ==== verilog/mem.sv ====
`timescale 1ns/10ps

module mem import mem_pkg::*; (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stage_valid_i,
    input  mem_stage_t      stage_i,
    input  mem_word_u       mem_data_i,
    output logic            wb_valid_o,
    output mem_wb_t         wb_o,
    output logic [XLEN-1:0] exception_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [1:0]      lane;
    logic [7:0]      byte_sel;
    logic [15:0]     half_sel;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wr_data;

    assign opcode = stage_i.inst[6:0];
    assign funct3 = stage_i.inst[14:12];
    assign lane   = stage_i.mem_addr[1:0];

    // ******************************
    // Load extraction
    // ******************************

    // Lane pick from low address bits
    assign byte_sel = mem_data_i.b[lane];
    assign half_sel = mem_data_i.h[lane[1]];

    always_comb begin
        case (funct3)
            F3_B:    load_data = {{24{byte_sel[7]}}, byte_sel};
            F3_H:    load_data = {{16{half_sel[15]}}, half_sel};
            F3_W:    load_data = mem_data_i.w;
            F3_BU:   load_data = {24'b0, byte_sel};
            F3_HU:   load_data = {16'b0, half_sel};
            default: load_data = '0;
        endcase
    end

    // Register write value
    always_comb begin
        case (opcode)
            OPC_OP_IMM,
            OPC_OP,
            OPC_JAL,
            OPC_JALR,
            OPC_LUI,
            OPC_AUIPC: wr_data = stage_i.rd_data;
            OPC_LOAD:  wr_data = load_data;
            // Stores and anything unknown
            default:   wr_data = '0;
        endcase
    end

    // ******************************
    // Writeback register
    // ******************************

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o   <= 1'b0;
            wb_o.regs_wen <= 1'b0;
            wb_o.csr_wen <= 1'b0;
            exception_o  <= '0;
        end else begin
            wb_valid_o    <= stage_valid_i;
            // Write enables only live alongside a valid result
            wb_o.regs_wen <= stage_valid_i & stage_i.regs_wen;
            wb_o.csr_wen  <= stage_valid_i & stage_i.csr_wen;
            exception_o   <= stage_valid_i ? stage_i.exception : '0;
            if (stage_valid_i) begin
                wb_o.inst        <= stage_i.inst;
                wb_o.inst_addr   <= stage_i.inst_addr;
                wb_o.rd_addr     <= stage_i.rd_addr;
                wb_o.rd_data     <= wr_data;
                wb_o.csr_wr_addr <= stage_i.csr_wr_addr;
                wb_o.csr_wr_data <= stage_i.csr_wr_data;
            end
        end
    end

endmodule

// ==== verilog/mem_access_ctrl.sv ====
`timescale 1ns/10ps

module mem_access_ctrl import mem_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       ex_valid_i,
    input  ex_mem_t    ex_i,
    output dmem_req_t  dmem_req_o,
    output logic       stage_valid_o,
    output mem_stage_t stage_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [1:0]      lane;
    logic            is_load;
    logic            is_store;
    logic            size_b;
    logic            size_h;
    logic            size_w;
    logic            misalign;
    logic            store_we;
    logic [3:0]      byte_en;
    mem_word_u       wdata;
    logic [XLEN-1:0] exc_flags;

    assign opcode   = ex_i.inst[6:0];
    assign funct3   = ex_i.inst[14:12];
    assign lane     = ex_i.mem_addr[1:0];
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);

    // Access size from funct3
    always_comb begin
        size_b = 1'b0;
        size_h = 1'b0;
        size_w = 1'b0;
        case (funct3)
            F3_B, F3_BU: size_b = 1'b1;
            F3_H, F3_HU: size_h = 1'b1;
            F3_W:        size_w = 1'b1;
            default:     size_b = 1'b0;
        endcase
    end

    // Halfword needs bit 0 clear, word needs bits 1:0 clear
    assign misalign = (size_h & lane[0]) | (size_w & (lane != 2'b00));
    assign store_we = ex_valid_i & is_store & ~misalign;

    always_comb begin
        byte_en = 4'b0000;
        wdata.w = ex_i.store_data;
        if (size_b) begin
            byte_en = 4'b0001 << lane;
            wdata.b = {4{ex_i.store_data[7:0]}};
        end else if (size_h) begin
            byte_en = lane[1] ? 4'b1100 : 4'b0011;
            wdata.h = {2{ex_i.store_data[15:0]}};
        end else if (size_w) begin
            byte_en = 4'b1111;
        end
    end

    // ******************************
    // RAM request, same cycle
    // ******************************

    // Misaligned loads still read, the result is dropped later
    assign dmem_req_o.en    = (ex_valid_i & is_load) | store_we;
    assign dmem_req_o.we    = store_we;
    assign dmem_req_o.be    = store_we ? byte_en : 4'b0000;
    assign dmem_req_o.addr  = ex_i.mem_addr[DMEM_AW+1:2];
    assign dmem_req_o.wdata = wdata;

    always_comb begin
        exc_flags = '0;
        exc_flags[EXC_LOAD_MISALIGN]  = is_load & misalign;
        exc_flags[EXC_STORE_MISALIGN] = is_store & misalign;
    end

    // ******************************
    // Stage record
    // ******************************

    always_ff @(posedge clk) begin
        if (reset_i) begin
            stage_valid_o <= 1'b0;
        end else begin
            stage_valid_o <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i) begin
            stage_o.inst        <= ex_i.inst;
            stage_o.inst_addr   <= ex_i.inst_addr;
            stage_o.regs_wen    <= ex_i.regs_wen & ~(is_load & misalign);
            stage_o.rd_addr     <= ex_i.rd_addr;
            stage_o.rd_data     <= ex_i.rd_data;
            stage_o.mem_addr    <= ex_i.mem_addr;
            stage_o.csr_wen     <= ex_i.csr_wen;
            stage_o.csr_wr_addr <= ex_i.csr_wr_addr;
            stage_o.csr_wr_data <= ex_i.csr_wr_data;
            stage_o.exception   <= ex_i.exception | exc_flags;
        end
    end

endmodule

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

`include "rv_opcodes.svh"

    // Widths and sizes
    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int CSR_AW     = 12;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;

    // Bit positions in the exception word
    localparam int EXC_LOAD_MISALIGN  = 4;
    localparam int EXC_STORE_MISALIGN = 6;

    localparam logic [6:0] OPC_LOAD   = `RV_OPC_LOAD;
    localparam logic [6:0] OPC_STORE  = `RV_OPC_STORE;
    localparam logic [6:0] OPC_OP_IMM = `RV_OPC_OP_IMM;
    localparam logic [6:0] OPC_OP     = `RV_OPC_OP;
    localparam logic [6:0] OPC_JAL    = `RV_OPC_JAL;
    localparam logic [6:0] OPC_JALR   = `RV_OPC_JALR;
    localparam logic [6:0] OPC_LUI    = `RV_OPC_LUI;
    localparam logic [6:0] OPC_AUIPC  = `RV_OPC_AUIPC;

    localparam logic [2:0] F3_B  = `RV_F3_B;
    localparam logic [2:0] F3_H  = `RV_F3_H;
    localparam logic [2:0] F3_W  = `RV_F3_W;
    localparam logic [2:0] F3_BU = `RV_F3_BU;
    localparam logic [2:0] F3_HU = `RV_F3_HU;

    // One RAM word, seen whole, by halfword or by byte lane
    typedef union packed {
        logic [XLEN-1:0]  w;
        logic [1:0][15:0] h;
        logic [3:0][7:0]  b;
    } mem_word_u;

    // ******************************
    // Stage records
    // ******************************

    typedef struct packed {
        logic [XLEN-1:0]   inst;
        logic [XLEN-1:0]   inst_addr;
        logic              regs_wen;
        logic [REG_AW-1:0] rd_addr;
        logic [XLEN-1:0]   rd_data;
        logic [XLEN-1:0]   mem_addr;
        logic [XLEN-1:0]   store_data;
        logic              csr_wen;
        logic [CSR_AW-1:0] csr_wr_addr;
        logic [XLEN-1:0]   csr_wr_data;
        logic [XLEN-1:0]   exception;
    } ex_mem_t;

    // Same as ex_mem_t minus store data
    typedef struct packed {
        logic [XLEN-1:0]   inst;
        logic [XLEN-1:0]   inst_addr;
        logic              regs_wen;
        logic [REG_AW-1:0] rd_addr;
        logic [XLEN-1:0]   rd_data;
        logic [XLEN-1:0]   mem_addr;
        logic              csr_wen;
        logic [CSR_AW-1:0] csr_wr_addr;
        logic [XLEN-1:0]   csr_wr_data;
        logic [XLEN-1:0]   exception;
    } mem_stage_t;

    typedef struct packed {
        logic               en;
        logic               we;
        logic [3:0]         be;
        logic [DMEM_AW-1:0] addr;
        mem_word_u          wdata;
    } dmem_req_t;

    typedef struct packed {
        logic [XLEN-1:0]   inst;
        logic [XLEN-1:0]   inst_addr;
        logic              regs_wen;
        logic [REG_AW-1:0] rd_addr;
        logic [XLEN-1:0]   rd_data;
        logic              csr_wen;
        logic [CSR_AW-1:0] csr_wr_addr;
        logic [XLEN-1:0]   csr_wr_data;
    } mem_wb_t;

endpackage

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/10ps

module mem_subsys_top import mem_pkg::*; (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            ex_valid_i,
    input  ex_mem_t         ex_i,
    output logic            wb_valid_o,
    output mem_wb_t         wb_o,
    output logic [XLEN-1:0] exception_o
);

    dmem_req_t  dmem_req;
    mem_word_u  ram_rdata;
    logic       stage_valid;
    mem_stage_t stage;

    // Decode, alignment and RAM request
    mem_access_ctrl i_mem_access_ctrl (
        .clk           (clk),
        .reset_i       (reset_i),
        .ex_valid_i    (ex_valid_i),
        .ex_i          (ex_i),
        .dmem_req_o    (dmem_req),
        .stage_valid_o (stage_valid),
        .stage_o       (stage)
    );

    data_ram i_data_ram (
        .clk     (clk),
        .req_i   (dmem_req),
        .rdata_o (ram_rdata)
    );

    // Extraction and writeback register
    mem i_mem (
        .clk           (clk),
        .reset_i       (reset_i),
        .stage_valid_i (stage_valid),
        .stage_i       (stage),
        .mem_data_i    (ram_rdata),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o),
        .exception_o   (exception_o)
    );

endmodule
